/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - mips_isa_pkg.sv
      - mips_core_pkg.sv
      - regfile.sv
      - alu.sv
      - decoder.sv
      - fetch_unit.sv
      - syscall_unit.sv
      - mips_core.sv
  - target: test
    files:
      - mips_core_checker.sv
      - tb_mips_core.sv

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
(
  input  alu_op_e alu_op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  always_comb begin
    case (alu_op)
      // add and sub wrap, no overflow trap
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      // signed compare
      alu_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      // immediate into upper half
      alu_lui: result = {b[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
(
  input  word_t    instr,
  output reg_idx_t rs,
  output reg_idx_t rt,
  output reg_idx_t rd_addr,
  output logic     reg_write,
  output logic     alu_src,
  output logic     is_jal,
  output logic     is_jr,
  output logic     is_j,
  output logic     is_syscall,
  output alu_op_e  alu_op,
  output word_t    imm,
  output pc_t      jump_target
);

  logic [5:0] opcode;
  logic [5:0] funct;

  // field split
  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];

  // r-type writes rd, i-type writes rt
  assign rd_addr = (opcode == op_rtype) ? instr[15:11] : instr[20:16];

  // word index shifted to bytes, upper nibble filled in by fetch
  assign jump_target = {4'b0000, instr[25:0], 2'b00};

  always_comb begin
    reg_write  = 1'b0;
    alu_src    = 1'b0;
    is_jal     = 1'b0;
    is_jr      = 1'b0;
    is_j       = 1'b0;
    is_syscall = 1'b0;
    alu_op     = alu_add;
    // sign extension unless the op says otherwise
    imm        = {{16{instr[15]}}, instr[15:0]};
    case (opcode)
      op_rtype: begin
        case (funct)
          fn_addu: begin
            reg_write = 1'b1;
            alu_op    = alu_add;
          end
          fn_subu: begin
            reg_write = 1'b1;
            alu_op    = alu_sub;
          end
          fn_and: begin
            reg_write = 1'b1;
            alu_op    = alu_and;
          end
          fn_or: begin
            reg_write = 1'b1;
            alu_op    = alu_or;
          end
          fn_slt: begin
            reg_write = 1'b1;
            alu_op    = alu_slt;
          end
          fn_jr:      is_jr = 1'b1;
          fn_syscall: is_syscall = 1'b1;
          // unknown funct runs as nop
          default: ;
        endcase
      end
      op_addiu: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        alu_op    = alu_add;
      end
      op_ori: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        alu_op    = alu_or;
        imm       = {16'h0000, instr[15:0]};
      end
      op_lui: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        alu_op    = alu_lui;
        imm       = {16'h0000, instr[15:0]};
      end
      op_j:   is_j = 1'b1;
      op_jal: is_jal = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
#(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          run,
  input  logic                          prog_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
  input  word_t                         prog_data,
  input  logic                          is_j,
  input  logic                          is_jal,
  input  logic                          is_jr,
  input  logic                          is_syscall,
  input  logic                          sys_done,
  input  logic                          sys_exit,
  input  pc_t                           jump_target,
  input  word_t                         jr_target,
  output word_t                         instr,
  output word_t                         pc_plus4,
  output logic                          commit
);

  localparam int AW = $clog2(IMEM_DEPTH);

  word_t        imem [IMEM_DEPTH];
  fetch_state_e state_q;
  pc_t          pc_q;
  pc_t          next_pc;

  // program load, only while stopped
  always_ff @(posedge clk) begin
    if (prog_we && !run) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // word addressed fetch
  assign instr    = imem[pc_q[AW+1:2]];
  assign pc_plus4 = pc_q + 32'd4;

  // register writes only land in run
  assign commit = (state_q == fs_run) && run;

  // next pc select
  always_comb begin
    if (is_jr) begin
      next_pc = jr_target;
    end else if (is_j || is_jal) begin
      // region bits come from pc + 4
      next_pc = {pc_plus4[31:28], jump_target[27:0]};
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fs_idle;
      pc_q    <= '0;
    end else begin
      case (state_q)
        fs_idle: begin
          // restart from address 0
          if (run) begin
            state_q <= fs_run;
            pc_q    <= '0;
          end
        end
        fs_run: begin
          if (!run) begin
            state_q <= fs_idle;
          end else if (is_syscall) begin
            // pc holds on the syscall until it is serviced
            state_q <= fs_wait_sys;
          end else begin
            pc_q <= next_pc;
          end
        end
        fs_wait_sys: begin
          if (sys_exit) begin
            state_q <= fs_halt;
          end else if (sys_done) begin
            state_q <= fs_run;
            pc_q    <= pc_plus4;
          end
        end
        // only reset leaves halt
        fs_halt: state_q <= fs_halt;
        default: state_q <= fs_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* flist.f */
mips_isa_pkg.sv
mips_core_pkg.sv
regfile.sv
alu.sv
decoder.sv
fetch_unit.sv
syscall_unit.sv
mips_core.sv
mips_core_checker.sv
tb_mips_core.sv

/* mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
#(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          run,
  input  logic                          prog_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
  input  word_t                         prog_data,
  output logic                          sys_req,
  output word_t                         sys_code,
  output word_t                         sys_arg,
  input  logic                          sys_ack,
  output logic                          halted
);

  // fetch side
  word_t    instr;
  word_t    pc_plus4;
  logic     commit;
  // decode side
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd_addr;
  logic     reg_write;
  logic     alu_src;
  logic     is_jal;
  logic     is_jr;
  logic     is_j;
  logic     is_syscall;
  alu_op_e  alu_op;
  word_t    imm;
  pc_t      jump_target;
  // datapath
  word_t    read1;
  word_t    read2;
  word_t    v0;
  word_t    a0;
  word_t    alu_b;
  word_t    alu_result;
  // syscall return path
  logic     sys_done;
  logic     sys_exit;

  fetch_unit #(
    .IMEM_DEPTH(IMEM_DEPTH)
  ) u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .is_j       (is_j),
    .is_jal     (is_jal),
    .is_jr      (is_jr),
    .is_syscall (is_syscall),
    .sys_done   (sys_done),
    .sys_exit   (sys_exit),
    .jump_target(jump_target),
    .jr_target  (read1),
    .instr      (instr),
    .pc_plus4   (pc_plus4),
    .commit     (commit)
  );

  decoder u_dec (
    .instr      (instr),
    .rs         (rs),
    .rt         (rt),
    .rd_addr    (rd_addr),
    .reg_write  (reg_write),
    .alu_src    (alu_src),
    .is_jal     (is_jal),
    .is_jr      (is_jr),
    .is_j       (is_j),
    .is_syscall (is_syscall),
    .alu_op     (alu_op),
    .imm        (imm),
    .jump_target(jump_target)
  );

  // writes and syscall start only count in an executing cycle
  regfile u_rf (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_write  (reg_write & commit),
    .is_jal     (is_jal & commit),
    .rs         (rs),
    .rt         (rt),
    .write_reg  (rd_addr),
    .write_data (alu_result),
    .jal_address(pc_plus4),
    .read1      (read1),
    .read2      (read2),
    .v0         (v0),
    .a0         (a0)
  );

  // immediate or rt operand
  assign alu_b = alu_src ? imm : read2;

  alu u_alu (
    .alu_op(alu_op),
    .a     (read1),
    .b     (alu_b),
    .result(alu_result)
  );

  syscall_unit u_sys (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (is_syscall & commit),
    .v0      (v0),
    .a0      (a0),
    .sys_ack (sys_ack),
    .sys_req (sys_req),
    .sys_code(sys_code),
    .sys_arg (sys_arg),
    .sys_done(sys_done),
    .sys_exit(sys_exit),
    .halted  (halted)
  );

endmodule

`default_nettype wire

/* mips_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core_checker
  import mips_isa_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  sys_req,
  input logic  sys_ack,
  input word_t sys_code,
  input word_t sys_arg,
  input logic  halted
);

  // failures seen so far, read by the testbench at the end
  int assert_fails = 0;

  // request stays up until it is acknowledged
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    sys_req && !sys_ack |=> sys_req)
    else begin
      $error("sys_req dropped before sys_ack");
      assert_fails++;
    end

  // payload frozen while the request is up
  payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sys_req |=> $stable(sys_code) && $stable(sys_arg))
    else begin
      $error("sys_code or sys_arg changed during a request");
      assert_fails++;
    end

  // req only falls in answer to ack
  req_fall_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(sys_req) |-> $past(sys_ack))
    else begin
      $error("sys_req fell without sys_ack");
      assert_fails++;
    end

  // a halted core is silent
  no_req_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !sys_req)
    else begin
      $error("sys_req high while halted");
      assert_fails++;
    end

  // halted is sticky until reset
  halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else begin
      $error("halted fell outside reset");
      assert_fails++;
    end

endmodule

`default_nettype wire

/* mips_core_pkg.sv */
`default_nettype none

package mips_core_pkg;

  // operations the alu knows
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_lui
  } alu_op_e;

  // fetch sequencing
  typedef enum logic [1:0] {
    fs_idle,
    fs_run,
    fs_wait_sys,
    fs_halt
  } fetch_state_e;

  // syscall service numbers, taken from v0
  typedef enum logic [31:0] {
    sys_print_int = 32'd1,
    sys_exit      = 32'd10
  } sys_code_e;

endpackage

`default_nettype wire

/* mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

  // basic word types
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] pc_t;

  // primary opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jal   = 6'h03;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lui   = 6'h0f;

  // r-type function codes, instr[5:0]
  localparam logic [5:0] fn_jr      = 6'h08;
  localparam logic [5:0] fn_syscall = 6'h0c;
  localparam logic [5:0] fn_addu    = 6'h21;
  localparam logic [5:0] fn_subu    = 6'h23;
  localparam logic [5:0] fn_and     = 6'h24;
  localparam logic [5:0] fn_or      = 6'h25;
  localparam logic [5:0] fn_slt     = 6'h2a;

  // registers with a fixed role
  localparam reg_idx_t reg_zero = 5'd0;
  localparam reg_idx_t reg_v0   = 5'd2;
  localparam reg_idx_t reg_a0   = 5'd4;
  localparam reg_idx_t reg_ra   = 5'd31;

endpackage

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile
  import mips_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     reg_write,
  input  logic     is_jal,
  input  reg_idx_t rs,
  input  reg_idx_t rt,
  input  reg_idx_t write_reg,
  input  word_t    write_data,
  input  word_t    jal_address,
  output word_t    read1,
  output word_t    read2,
  output word_t    v0,
  output word_t    a0
);

  word_t regs [32];

  // write port, rising edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // r0 is never written
      if (reg_write && (write_reg != reg_zero)) begin
        regs[write_reg] <= write_data;
      end
      // link write comes last so it wins on ra
      if (is_jal) begin
        regs[reg_ra] <= jal_address;
      end
    end
  end

  // combinational reads, r0 forced to zero
  assign read1 = (rs == reg_zero) ? '0 : regs[rs];
  assign read2 = (rt == reg_zero) ? '0 : regs[rt];

  // taps for the syscall unit
  assign v0 = regs[reg_v0];
  assign a0 = regs[reg_a0];

endmodule

`default_nettype wire

/* syscall_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module syscall_unit
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  word_t v0,
  input  word_t a0,
  input  logic  sys_ack,
  output logic  sys_req,
  output word_t sys_code,
  output word_t sys_arg,
  output logic  sys_done,
  output logic  sys_exit,
  output logic  halted
);

  // handshake phase
  typedef enum logic [1:0] {
    ph_idle,
    ph_req,
    ph_drop
  } phase_e;

  phase_e phase_q;

  // code and argument captured at start, held over the whole handshake
  always_ff @(posedge clk) begin
    if (start && (phase_q == ph_idle)) begin
      sys_code <= v0;
      sys_arg  <= a0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q  <= ph_idle;
      sys_req  <= 1'b0;
      sys_done <= 1'b0;
      sys_exit <= 1'b0;
      halted   <= 1'b0;
    end else begin
      // one cycle pulses
      sys_done <= 1'b0;
      sys_exit <= 1'b0;
      case (phase_q)
        ph_idle: begin
          if (start && !halted) begin
            if (v0 == word_t'(sys_print_int)) begin
              sys_req <= 1'b1;
              phase_q <= ph_req;
            end else if (v0 == word_t'(mips_core_pkg::sys_exit)) begin
              // exit, no request goes out
              sys_exit <= 1'b1;
              halted   <= 1'b1;
            end else begin
              // unknown service finishes at once
              sys_done <= 1'b1;
            end
          end
        end
        ph_req: begin
          if (sys_ack) begin
            sys_req <= 1'b0;
            phase_q <= ph_drop;
          end
        end
        ph_drop: begin
          // wait for ack low, then release fetch
          if (!sys_ack) begin
            sys_done <= 1'b1;
            phase_q  <= ph_idle;
          end
        end
        default: phase_q <= ph_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core
  import mips_isa_pkg::*;
;

  localparam int IMEM_DEPTH = 64;
  localparam int AW = $clog2(IMEM_DEPTH);
  // scratch registers used by the programs
  localparam reg_idx_t reg_t0 = 5'd8;
  localparam reg_idx_t reg_t1 = 5'd9;
  localparam reg_idx_t reg_t2 = 5'd10;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          run;
  logic          prog_we;
  logic [AW-1:0] prog_addr;
  word_t         prog_data;
  logic          sys_req;
  word_t         sys_code;
  word_t         sys_arg;
  logic          sys_ack;
  logic          halted;

  // program image and expected prints
  word_t prog_mem [IMEM_DEPTH];
  int    prog_len;
  word_t exp_q [$];

  string test_name = "init";
  int    max_delay = 0;
  int    err_count = 0;
  int    check_count = 0;
  int    cycle_count = 0;
  int    cycle_limit = 200;

  mips_core #(
    .IMEM_DEPTH(IMEM_DEPTH)
  ) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .prog_we  (prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .sys_req  (sys_req),
    .sys_code (sys_code),
    .sys_arg  (sys_arg),
    .sys_ack  (sys_ack),
    .halted   (halted)
  );

  bind mips_core mips_core_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .sys_req (sys_req),
    .sys_ack (sys_ack),
    .sys_code(sys_code),
    .sys_arg (sys_arg),
    .halted  (halted)
  );

  always #10 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles in test %s", cycle_count, test_name);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // instruction encoders
  function automatic word_t enc_r(logic [5:0] fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
    return {op_rtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t enc_i(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                  logic [15:0] im);
    return {op, rs, rt, im};
  endfunction

  function automatic word_t enc_j(logic [5:0] op, int word_idx);
    return {op, 26'(word_idx)};
  endfunction

  task automatic emit(word_t w);
    prog_mem[prog_len] = w;
    prog_len++;
  endtask

  task automatic clear_program();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      prog_mem[i] = '0;
    end
    prog_len = 0;
  endtask

  // a0 = r, then print (v0 set to 1 beforehand)
  task automatic print_reg(reg_idx_t r);
    emit(enc_r(fn_addu, r, reg_zero, reg_a0));
    emit(enc_r(fn_syscall, reg_zero, reg_zero, reg_zero));
  endtask

  task automatic emit_exit();
    emit(enc_i(op_addiu, reg_zero, reg_v0, 16'd10));
    emit(enc_r(fn_syscall, reg_zero, reg_zero, reg_zero));
  endtask

  // reference interpreter, fills exp_q, returns executed count or -1
  function automatic int ref_run();
    word_t       r [32];
    word_t       pc;
    word_t       nxt;
    word_t       ins;
    logic [5:0]  op;
    logic [5:0]  fn;
    reg_idx_t    s;
    reg_idx_t    t;
    reg_idx_t    d;
    logic [15:0] im;
    int          steps;
    for (int i = 0; i < 32; i++) begin
      r[i] = '0;
    end
    pc = '0;
    steps = 0;
    while (steps < 1000) begin
      ins = prog_mem[pc[AW+1:2]];
      steps++;
      op = ins[31:26];
      fn = ins[5:0];
      s = ins[25:21];
      t = ins[20:16];
      d = ins[15:11];
      im = ins[15:0];
      nxt = pc + 32'd4;
      case (op)
        op_rtype: begin
          case (fn)
            fn_addu: r[d] = r[s] + r[t];
            fn_subu: r[d] = r[s] - r[t];
            fn_and:  r[d] = r[s] & r[t];
            fn_or:   r[d] = r[s] | r[t];
            fn_slt: begin
              // mixed signs decide on the sign bit alone
              if (r[s][31] != r[t][31]) begin
                r[d] = {31'd0, r[s][31]};
              end else begin
                // same sign orders like unsigned
                r[d] = {31'd0, (r[s] < r[t])};
              end
            end
            fn_jr:   nxt = r[s];
            fn_syscall: begin
              if (r[2] == 32'd10) begin
                return steps;
              end
              if (r[2] == 32'd1) begin
                exp_q.push_back(r[4]);
              end
            end
            default: ;
          endcase
        end
        op_addiu: r[t] = r[s] + {{16{im[15]}}, im};
        op_ori:   r[t] = r[s] | {16'h0000, im};
        op_lui:   r[t] = {im, 16'h0000};
        op_j:     nxt = {nxt[31:28], ins[25:0], 2'b00};
        op_jal: begin
          r[31] = pc + 32'd4;
          nxt = {nxt[31:28], ins[25:0], 2'b00};
        end
        default: ;
      endcase
      // r0 is hardwired
      r[0] = '0;
      pc = nxt;
    end
    return -1;
  endfunction

  task automatic check_value(string what, word_t exp, word_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // random operands, including a negative one for signed slt
  task automatic build_arith();
    word_t       a;
    word_t       b;
    logic [15:0] im;
    a = $urandom | 32'h8000_0000;
    b = $urandom & 32'h7fff_ffff;
    im = 16'($urandom);
    clear_program();
    emit(enc_i(op_addiu, reg_zero, reg_v0, 16'd1));
    emit(enc_i(op_lui, reg_zero, reg_t0, a[31:16]));
    emit(enc_i(op_ori, reg_t0, reg_t0, a[15:0]));
    emit(enc_i(op_lui, reg_zero, reg_t1, b[31:16]));
    emit(enc_i(op_ori, reg_t1, reg_t1, b[15:0]));
    emit(enc_i(op_addiu, reg_t0, reg_t2, im));
    print_reg(reg_t2);
    emit(enc_i(op_lui, reg_zero, reg_t2, im));
    print_reg(reg_t2);
    emit(enc_i(op_ori, reg_t1, reg_t2, im));
    print_reg(reg_t2);
    emit(enc_r(fn_addu, reg_t0, reg_t1, reg_t2));
    print_reg(reg_t2);
    emit(enc_r(fn_subu, reg_t1, reg_t0, reg_t2));
    print_reg(reg_t2);
    emit(enc_r(fn_and, reg_t0, reg_t1, reg_t2));
    print_reg(reg_t2);
    emit(enc_r(fn_or, reg_t0, reg_t1, reg_t2));
    print_reg(reg_t2);
    emit(enc_r(fn_slt, reg_t0, reg_t1, reg_t2));
    print_reg(reg_t2);
    emit(enc_r(fn_slt, reg_t1, reg_t0, reg_t2));
    print_reg(reg_t2);
    emit_exit();
  endtask

  task automatic build_zero();
    clear_program();
    emit(enc_i(op_addiu, reg_zero, reg_v0, 16'd1));
    emit(enc_i(op_addiu, reg_zero, reg_t0, 16'h1234));
    // a0 nonzero first, so a later zero print means something
    print_reg(reg_t0);
    emit(enc_i(op_addiu, reg_zero, reg_zero, 16'h0055));
    emit(enc_i(op_lui, reg_zero, reg_zero, 16'hbeef));
    emit(enc_r(fn_addu, reg_t0, reg_t0, reg_zero));
    print_reg(reg_zero);
    emit(enc_i(op_ori, reg_zero, reg_t2, 16'h0000));
    print_reg(reg_t2);
    emit_exit();
  endtask

  // subroutine at word 12, j over words 6 and 7
  task automatic build_jumps();
    clear_program();
    emit(enc_i(op_addiu, reg_zero, reg_v0, 16'd1));
    emit(enc_i(op_addiu, reg_zero, reg_t0, 16'd7));
    emit(enc_j(op_jal, 12));
    emit(enc_i(op_addiu, reg_zero, reg_t0, 16'd9));
    emit(enc_j(op_jal, 12));
    emit(enc_j(op_j, 8));
    emit(enc_i(op_addiu, reg_zero, reg_t0, 16'h0066));
    emit(enc_r(fn_syscall, reg_zero, reg_zero, reg_zero));
    print_reg(reg_ra);
    emit_exit();
    print_reg(reg_t0);
    emit(enc_r(fn_jr, reg_ra, reg_zero, reg_zero));
  endtask

  // exit first, the print behind it must never happen
  task automatic build_exit();
    clear_program();
    emit_exit();
    emit(enc_i(op_addiu, reg_zero, reg_v0, 16'd1));
    print_reg(reg_v0);
    emit_exit();
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(negedge clk);
      prog_we = 1'b1;
      prog_addr = AW'(i);
      prog_data = prog_mem[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
  endtask

  task automatic run_test(string name, int delay);
    int n;
    test_name = name;
    max_delay = delay;
    exp_q.delete();
    n = ref_run();
    if (n < 0) begin
      err_count++;
      $display("%s: reference model never reached the exit syscall", name);
      n = 1000;
    end
    // reset, load, tail, then worst handshake cost per instruction
    cycle_limit += 8 + 2 * IMEM_DEPTH + 60 + n * (2 * (delay + 1) + 6);
    apply_reset();
    @(negedge clk);
    check_value("sys_req after reset", 32'd0, {31'd0, sys_req});
    check_value("halted after reset", 32'd0, {31'd0, halted});
    load_program();
    run = 1'b1;
    while (!halted) begin
      @(negedge clk);
    end
    // quiet window after exit, the responder flags any request
    repeat (10) @(negedge clk);
    if (exp_q.size() != 0) begin
      err_count++;
      $display("%s: %0d expected prints never arrived", name, exp_q.size());
    end
    run = 1'b0;
  endtask

  // handshake responder and compare process
  task automatic answer_request();
    word_t exp;
    if (halted) begin
      err_count++;
      $display("%s: sys_req raised while halted", test_name);
    end
    if (exp_q.size() == 0) begin
      err_count++;
      $display("%s: print request beyond the expected prints", test_name);
    end else begin
      exp = exp_q.pop_front();
      check_value("sys_code", 32'd1, sys_code);
      check_value("sys_arg", exp, sys_arg);
    end
    repeat ($urandom_range(max_delay, 0)) @(negedge clk);
    sys_ack = 1'b1;
    do begin
      @(negedge clk);
    end while (sys_req);
    repeat ($urandom_range(max_delay, 0)) @(negedge clk);
    sys_ack = 1'b0;
  endtask

  // looks for a print request on every falling edge
  task automatic respond_to_syscalls();
    forever begin
      @(negedge clk);
      if (sys_req) begin
        answer_request();
      end
    end
  endtask

  initial begin : main
    int total;
    void'($urandom(60329));
    rst_n = 1'b0;
    run = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    sys_ack = 1'b0;
    fork
      respond_to_syscalls();
    join_none
    build_arith();
    run_test("arith", 0);
    build_zero();
    run_test("reg_zero", 0);
    build_jumps();
    run_test("jumps", 0);
    build_arith();
    run_test("backpressure_arith", 15);
    build_jumps();
    run_test("backpressure_jumps", 15);
    build_exit();
    run_test("exit", 0);
    total = err_count + dut0.u_checker.assert_fails;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, err_count, dut0.u_checker.assert_fails);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
